//--- verilog/vchess_cfg.svh
`ifndef VCHESS_CFG_SVH
`define VCHESS_CFG_SVH

// Board geometry
`define PIECE_WIDTH    4                 // Color bit plus 3-bit kind
`define RANK_SQUARES   8
`define BOARD_WIDTH    256
`define BOARD_RANKS    (`BOARD_WIDTH / (`RANK_SQUARES * `PIECE_WIDTH))

`define EVAL_WIDTH     24                // Signed width of every score

// Middlegame piece values
`define MG_PAWN        100
`define MG_KNIGHT      320
`define MG_BISHOP      330
`define MG_ROOK        500
`define MG_QUEEN       900

// Endgame piece values
`define EG_PAWN        120
`define EG_KNIGHT      300
`define EG_BISHOP      320
`define EG_ROOK        520
`define EG_QUEEN       950

`define KING_VALUE     0                 // Both phases

// Per attacked square
`define MOB_WEIGHT_MG  4
`define MOB_WEIGHT_EG  2

// Taper, 2^20 / 62 truncated
`define PHASE_MAX      62
`define PHASE_SHIFT    20
`define PHASE_SCALE    16912

`define EVAL_LATENCY   8

`endif

//--- verilog/board_pkg.sv
`include "vchess_cfg.svh"

package board_pkg;

   // Piece kind without color, code 7 never appears on a legal board
   typedef enum logic [`PIECE_WIDTH-2:0]
   {
      piece_empty  = 3'd0,
      piece_pawn   = 3'd1,
      piece_knight = 3'd2,
      piece_bishop = 3'd3,
      piece_rook   = 3'd4,
      piece_queen  = 3'd5,
      piece_king   = 3'd6
   } piece_kind_e;

   // One square, color in the top bit
   typedef struct packed
   {
      logic        black;          // Set for a black piece
      piece_kind_e kind;
   } square_t;

   // Rank r holds squares 8r up to 8r+7, lowest square in the low bits
   typedef square_t [`RANK_SQUARES-1:0] rank_t;

   // Square s at bits 4s and up
   typedef rank_t [`BOARD_RANKS-1:0] board_t;

endpackage

//--- verilog/eval_pkg.sv
`include "vchess_cfg.svh"

package eval_pkg;

   // Partial score of one rank, white positive
   typedef struct packed
   {
      logic signed [`EVAL_WIDTH-1:0] mg;
      logic signed [`EVAL_WIDTH-1:0] eg;
      logic [3:0]                    occupied;
      logic [3:0]                    heavy;          // Pawns, rooks and queens
      logic [3:0]                    minors_white;
      logic [3:0]                    minors_black;
   } rank_score_t;

   // Whole board after mobility
   typedef struct packed
   {
      logic signed [`EVAL_WIDTH-1:0] mg;
      logic signed [`EVAL_WIDTH-1:0] eg;
      logic signed [`EVAL_WIDTH-1:0] material;       // Middlegame sum before mobility
      logic [6:0]                    occupied;       // Up to 64
      logic                          insufficient;
   } total_score_t;

endpackage

//--- verilog/rank_scorer.sv
`timescale 1ns/1ps
`include "vchess_cfg.svh"

module rank_scorer
   (
      input  logic                  clk,
      input  board_pkg::rank_t      rank,
      output eval_pkg::rank_score_t score
   );

   eval_pkg::rank_score_t sum;
   logic                  has_illegal;

   function automatic logic signed [`EVAL_WIDTH-1:0] mg_value(board_pkg::piece_kind_e kind);
      case (kind)
         board_pkg::piece_pawn:   mg_value = `MG_PAWN;
         board_pkg::piece_knight: mg_value = `MG_KNIGHT;
         board_pkg::piece_bishop: mg_value = `MG_BISHOP;
         board_pkg::piece_rook:   mg_value = `MG_ROOK;
         board_pkg::piece_queen:  mg_value = `MG_QUEEN;
         board_pkg::piece_king:   mg_value = `KING_VALUE;
         default:                 mg_value = '0;
      endcase
   endfunction

   function automatic logic signed [`EVAL_WIDTH-1:0] eg_value(board_pkg::piece_kind_e kind);
      case (kind)
         board_pkg::piece_pawn:   eg_value = `EG_PAWN;
         board_pkg::piece_knight: eg_value = `EG_KNIGHT;
         board_pkg::piece_bishop: eg_value = `EG_BISHOP;
         board_pkg::piece_rook:   eg_value = `EG_ROOK;
         board_pkg::piece_queen:  eg_value = `EG_QUEEN;
         board_pkg::piece_king:   eg_value = `KING_VALUE;
         default:                 eg_value = '0;
      endcase
   endfunction

   always_comb
   begin
      sum = '0;
      has_illegal = 1'b0;
      for (int i = 0; i < `RANK_SQUARES; i++)
      begin
         if (rank[i].black)   // Black counts against white
         begin
            sum.mg = sum.mg - mg_value(rank[i].kind);
            sum.eg = sum.eg - eg_value(rank[i].kind);
         end
         else
         begin
            sum.mg = sum.mg + mg_value(rank[i].kind);
            sum.eg = sum.eg + eg_value(rank[i].kind);
         end
         if (rank[i].kind != board_pkg::piece_empty)
            sum.occupied = sum.occupied + 4'd1;
         if (rank[i].kind == board_pkg::piece_pawn || rank[i].kind == board_pkg::piece_rook ||
             rank[i].kind == board_pkg::piece_queen)
            sum.heavy = sum.heavy + 4'd1;
         if (rank[i].kind == board_pkg::piece_knight || rank[i].kind == board_pkg::piece_bishop)
         begin
            if (rank[i].black)
               sum.minors_black = sum.minors_black + 4'd1;
            else
               sum.minors_white = sum.minors_white + 4'd1;
         end
         if (rank[i].kind == 3'd7)
            has_illegal = 1'b1;
      end
   end

   always_ff @(posedge clk)
      score <= sum;

   // Board register upstream must never hold the unused kind code
   assert property (@(posedge clk) !$isunknown(rank) |-> !has_illegal)
      else $error("rank_scorer: illegal piece code on rank input");

endmodule

//--- verilog/score_accumulate.sv
`timescale 1ns/1ps
`include "vchess_cfg.svh"

module score_accumulate
   (
      input  logic                   clk,
      input  eval_pkg::rank_score_t  partials [`BOARD_RANKS],
      input  logic [5:0]             attack_white_pop,
      input  logic [5:0]             attack_black_pop,
      output eval_pkg::total_score_t total
   );

   localparam logic signed [`EVAL_WIDTH-1:0] mob_mg = `MOB_WEIGHT_MG;
   localparam logic signed [`EVAL_WIDTH-1:0] mob_eg = `MOB_WEIGHT_EG;

   logic signed [`EVAL_WIDTH-1:0] mg_sum;
   logic signed [`EVAL_WIDTH-1:0] eg_sum;
   logic [6:0]                    occupied_sum;
   logic [6:0]                    heavy_sum;
   logic [6:0]                    minors_white_sum;
   logic [6:0]                    minors_black_sum;
   logic signed [6:0]             pop_diff;
   logic signed [`EVAL_WIDTH-1:0] mob_diff;
   eval_pkg::total_score_t        next_total;

   always_comb
   begin
      mg_sum = '0;
      eg_sum = '0;
      occupied_sum = '0;
      heavy_sum = '0;
      minors_white_sum = '0;
      minors_black_sum = '0;
      for (int r = 0; r < `BOARD_RANKS; r++)
      begin
         mg_sum = mg_sum + $signed(partials[r].mg);
         eg_sum = eg_sum + $signed(partials[r].eg);
         occupied_sum = occupied_sum + {3'd0, partials[r].occupied};
         heavy_sum = heavy_sum + {3'd0, partials[r].heavy};
         minors_white_sum = minors_white_sum + {3'd0, partials[r].minors_white};
         minors_black_sum = minors_black_sum + {3'd0, partials[r].minors_black};
      end
   end

   // Attacked squares, white minus black
   assign pop_diff = $signed({1'b0, attack_white_pop}) - $signed({1'b0, attack_black_pop});
   assign mob_diff = pop_diff;   // Sign extended

   always_comb
   begin
      next_total.material = mg_sum;
      next_total.mg = mg_sum + mob_diff * mob_mg;
      next_total.eg = eg_sum + mob_diff * mob_eg;
      next_total.occupied = occupied_sum;
      // Bare kings, or one knight or bishop per side at most
      next_total.insufficient = (heavy_sum == 7'd0) && (minors_white_sum <= 7'd1) &&
                                (minors_black_sum <= 7'd1);
   end

   always_ff @(posedge clk)
      total <= next_total;

endmodule

//--- verilog/phase_blend.sv
`timescale 1ns/1ps
`include "vchess_cfg.svh"

module phase_blend
   (
      input  logic                          clk,
      input  eval_pkg::total_score_t        total,
      input  logic                          white_to_move,
      output logic signed [`EVAL_WIDTH-1:0] eval
   );

   // Score times phase times scale, plus sign and headroom
   localparam int calc_width = `EVAL_WIDTH + 8 + 1 + $clog2(`PHASE_SCALE + 1);

   localparam logic [5:0]                  phase_max   = `PHASE_MAX;
   localparam logic signed [calc_width-1:0] phase_scale = `PHASE_SCALE;
   localparam logic signed [calc_width-1:0] round_bias  = (1 << `PHASE_SHIFT) - 1;

   logic [5:0]                    phase_s1;
   logic signed [`EVAL_WIDTH-1:0] mg_s1;
   logic signed [`EVAL_WIDTH-1:0] eg_s1;
   logic signed [calc_width-1:0]  mg_s2;
   logic signed [calc_width-1:0]  eg_s2;
   logic signed [calc_width-1:0]  sum_s3;
   logic signed [calc_width-1:0]  scaled_s4;
   logic signed [calc_width-1:0]  biased;
   logic signed [calc_width-1:0]  shifted;
   logic signed [`EVAL_WIDTH-1:0] blended;

   // Phase from occupied squares, capped
   always_ff @(posedge clk)
   begin
      if (total.occupied > {1'b0, phase_max})
         phase_s1 <= phase_max;
      else
         phase_s1 <= total.occupied[5:0];
      mg_s1 <= $signed(total.mg);
      eg_s1 <= $signed(total.eg);
   end

   // Middlegame weighted by phase, endgame by the rest
   always_ff @(posedge clk)
   begin
      mg_s2 <= mg_s1 * $signed({1'b0, phase_s1});
      eg_s2 <= eg_s1 * $signed({1'b0, phase_max - phase_s1});
   end

   always_ff @(posedge clk)
      sum_s3 <= mg_s2 + eg_s2;

   always_ff @(posedge clk)
      scaled_s4 <= sum_s3 * phase_scale;   // Same as dividing by 62 after the shift

   // Bias negatives so the shift truncates toward zero
   assign biased  = scaled_s4 + ((scaled_s4 < 0) ? round_bias : '0);
   assign shifted = biased >>> `PHASE_SHIFT;
   assign blended = shifted[`EVAL_WIDTH-1:0];

   always_ff @(posedge clk)
      eval <= white_to_move ? blended : -blended;   // Side to move view

   // Occupancy feeding the phase cap never exceeds the squares on a board
   assert property (@(posedge clk) !$isunknown(total.occupied) |-> total.occupied <= 7'd64)
      else $error("phase_blend: occupied count above board size");

endmodule

//--- verilog/evaluate.sv
`timescale 1ns/1ps
`include "vchess_cfg.svh"

module evaluate
   (
      input  logic                          clk,
      input  logic                          reset,
      input  logic                          board_valid,
      input  logic                          is_attacking_done,
      input  board_pkg::board_t             board_in,
      input  logic                          clear_eval,
      input  logic                          white_to_move,
      input  logic [5:0]                    attack_white_pop,
      input  logic [5:0]                    attack_black_pop,
      output logic                          insufficient_material,
      output logic signed [`EVAL_WIDTH-1:0] eval,
      output logic                          eval_valid,
      output logic signed [31:0]            material
   );

   typedef enum logic [1:0]
   {
      st_idle,
      st_wait_attack,
      st_wait_latency,
      st_wait_clear
   } state_e;

   localparam int lat_width = $clog2(`EVAL_LATENCY + 1);
   localparam logic [lat_width-1:0] lat_last = `EVAL_LATENCY;

   state_e                 state;
   logic [lat_width-1:0]   lat_count;
   board_pkg::board_t      board_q;
   eval_pkg::rank_score_t  partials [`BOARD_RANKS];
   eval_pkg::total_score_t total;

   // Control FSM
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= st_idle;
         eval_valid <= 1'b0;
         lat_count <= '0;
      end
      else
      begin
         case (state)
            st_idle:
            begin
               eval_valid <= 1'b0;
               if (board_valid)
                  state <= st_wait_attack;
            end
            st_wait_attack:
            begin
               if (is_attacking_done)
               begin
                  lat_count <= '0;
                  state <= st_wait_latency;
               end
            end
            st_wait_latency:
            begin
               // Leaves on the ninth edge after is_attacking_done
               lat_count <= lat_count + 1'b1;
               if (lat_count == lat_last)
               begin
                  eval_valid <= 1'b1;
                  state <= st_wait_clear;
               end
            end
            st_wait_clear:
            begin
               if (clear_eval)
               begin
                  eval_valid <= 1'b0;
                  state <= st_idle;
               end
            end
            default:
               state <= st_idle;
         endcase
      end
   end

   // Tracks board_in while idle, frozen afterwards
   always_ff @(posedge clk)
   begin
      if (state == st_idle)
         board_q <= board_in;
   end

   genvar r;
   generate
      for (r = 0; r < `BOARD_RANKS; r++)
      begin : g_rank
         rank_scorer u_rank_scorer
            (
               .clk   (clk),
               .rank  (board_q[r]),
               .score (partials[r])
            );
      end
   endgenerate

   score_accumulate u_score_accumulate
      (
         .clk              (clk),
         .partials         (partials),
         .attack_white_pop (attack_white_pop),
         .attack_black_pop (attack_black_pop),
         .total            (total)
      );

   phase_blend u_phase_blend
      (
         .clk           (clk),
         .total         (total),
         .white_to_move (white_to_move),
         .eval          (eval)
      );

   assign material = 32'($signed(total.material));   // Sign extended
   assign insufficient_material = total.insufficient;

   assert property (@(posedge clk) disable iff (reset) eval_valid |-> state != st_idle)
      else $error("evaluate: eval_valid high while idle");

   // Result strobe lands a fixed number of edges after the attack generator finishes
   assert property (@(posedge clk) disable iff (reset)
                    (state == st_wait_attack) && is_attacking_done
                    |-> ##(`EVAL_LATENCY + 1) !eval_valid ##1 eval_valid)
      else $error("evaluate: eval_valid early or late");

endmodule

//--- testbench/tb_eval_table.svh
`ifndef TB_EVAL_TABLE_SVH
`define TB_EVAL_TABLE_SVH

// Columns of one row: board, side to move, white pop, black pop
typedef struct packed
{
   board_pkg::board_t board;
   logic              white_to_move;
   logic [5:0]        white_pop;
   logic [5:0]        black_pop;
} stim_t;

typedef struct packed
{
   logic signed [`EVAL_WIDTH-1:0] eval;
   logic signed [31:0]            material;
   logic                          insufficient;
} expect_t;

// Indexed by kind code, empty first
localparam int mg_of_kind [7] = '{0, `MG_PAWN, `MG_KNIGHT, `MG_BISHOP, `MG_ROOK, `MG_QUEEN,
                                  `KING_VALUE};
localparam int eg_of_kind [7] = '{0, `EG_PAWN, `EG_KNIGHT, `EG_BISHOP, `EG_ROOK, `EG_QUEEN,
                                  `KING_VALUE};

stim_t rows [$];
string row_names [$];

function automatic board_pkg::board_t put_piece(board_pkg::board_t board, int sq, logic black,
                                                board_pkg::piece_kind_e kind);
   board[sq / 8][sq % 8].black = black;
   board[sq / 8][sq % 8].kind = kind;
   return board;
endfunction

// Reference score straight from the evaluation rules
function automatic expect_t model_eval(stim_t s);
   int      mg;
   int      eg;
   int      occupied;
   int      heavy;
   int      minors_w;
   int      minors_b;
   int      kind;
   int      sign;
   int      phase;
   int      pop_diff;
   longint  blend;
   expect_t e;
   mg = 0;
   eg = 0;
   occupied = 0;
   heavy = 0;
   minors_w = 0;
   minors_b = 0;
   for (int i = 0; i < 64; i++)
   begin
      kind = int'(s.board[i / 8][i % 8].kind);
      sign = s.board[i / 8][i % 8].black ? -1 : 1;
      mg = mg + sign * mg_of_kind[kind];
      eg = eg + sign * eg_of_kind[kind];
      if (kind != 0)
         occupied++;
      if (kind == 1 || kind == 4 || kind == 5)
         heavy++;
      if ((kind == 2 || kind == 3) && sign < 0)
         minors_b++;
      else if (kind == 2 || kind == 3)
         minors_w++;
   end
   e.material = 32'(mg);
   e.insufficient = (heavy == 0) && (minors_w <= 1) && (minors_b <= 1);
   pop_diff = int'(s.white_pop) - int'(s.black_pop);
   mg = mg + pop_diff * `MOB_WEIGHT_MG;
   eg = eg + pop_diff * `MOB_WEIGHT_EG;
   phase = (occupied > `PHASE_MAX) ? `PHASE_MAX : occupied;
   blend = longint'(mg * phase + eg * (`PHASE_MAX - phase)) * `PHASE_SCALE;
   blend = blend / (64'sd1 << `PHASE_SHIFT);   // Signed divide truncates toward zero
   if (!s.white_to_move)
      blend = -blend;
   e.eval = blend[`EVAL_WIDTH-1:0];
   return e;
endfunction

`endif

//--- testbench/tb_evaluate.sv
`timescale 1ns/1ps
`include "vchess_cfg.svh"

module tb_evaluate;

   logic                          clk;
   logic                          reset;
   logic                          board_valid;
   logic                          is_attacking_done;
   board_pkg::board_t             board_in;
   logic                          clear_eval;
   logic                          white_to_move;
   logic [5:0]                    attack_white_pop;
   logic [5:0]                    attack_black_pop;
   logic                          insufficient_material;
   logic signed [`EVAL_WIDTH-1:0] eval;
   logic                          eval_valid;
   logic signed [31:0]            material;

   `include "tb_eval_table.svh"

   evaluate dut
      (
         .clk                   (clk),
         .reset                 (reset),
         .board_valid           (board_valid),
         .is_attacking_done     (is_attacking_done),
         .board_in              (board_in),
         .clear_eval            (clear_eval),
         .white_to_move         (white_to_move),
         .attack_white_pop      (attack_white_pop),
         .attack_black_pop      (attack_black_pop),
         .insufficient_material (insufficient_material),
         .eval                  (eval),
         .eval_valid            (eval_valid),
         .material              (material)
      );

   always #20 clk = ~clk;   // 40 ns period

   task automatic stop_with_failure(string why);
      $display("%s", why);
      $display("RESULT: FAIL");
      $fatal(1, "Simulation stopped on first failure");
   endtask

   task automatic check_eval(string name, logic signed [`EVAL_WIDTH-1:0] expected,
                             logic signed [`EVAL_WIDTH-1:0] actual);
      if (actual !== expected)
         stop_with_failure($sformatf("[ERROR] %s eval expected %0d actual %0d",
                                     name, expected, actual));
   endtask

   task automatic check_material(string name, logic signed [31:0] expected,
                                 logic signed [31:0] actual);
      if (actual !== expected)
         stop_with_failure($sformatf("[ERROR] %s material expected %0d actual %0d",
                                     name, expected, actual));
   endtask

   task automatic check_flag(string name, logic expected, logic actual);
      if (actual !== expected)
         stop_with_failure($sformatf("[ERROR] %s expected %b actual %b", name, expected, actual));
   endtask

   task automatic add_row(string name, board_pkg::board_t board, logic wtm, int wpop, int bpop);
      stim_t row;
      row.board = board;
      row.white_to_move = wtm;
      row.white_pop = 6'(wpop);
      row.black_pop = 6'(bpop);
      rows.push_back(row);
      row_names.push_back(name);
   endtask

   task automatic build_table();
      board_pkg::board_t      start;
      board_pkg::board_t      kings;
      board_pkg::board_t      b;
      board_pkg::piece_kind_e back [8];
      start = '0;
      back = '{board_pkg::piece_rook, board_pkg::piece_knight, board_pkg::piece_bishop,
               board_pkg::piece_queen, board_pkg::piece_king, board_pkg::piece_bishop,
               board_pkg::piece_knight, board_pkg::piece_rook};
      for (int f = 0; f < 8; f++)
      begin
         start = put_piece(start, f, 1'b0, back[f]);
         start = put_piece(start, 8 + f, 1'b0, board_pkg::piece_pawn);
         start = put_piece(start, 48 + f, 1'b1, board_pkg::piece_pawn);
         start = put_piece(start, 56 + f, 1'b1, back[f]);
      end
      add_row("start_position", start, 1'b1, 20, 20);
      add_row("start_black_to_move", start, 1'b0, 20, 20);
      add_row("start_mobility", start, 1'b1, 30, 12);
      add_row("start_mobility_btm", start, 1'b0, 30, 12);
      b = put_piece(start, 63, 1'b0, board_pkg::piece_empty);   // Black rook gone
      add_row("missing_black_rook", b, 1'b1, 14, 14);
      add_row("missing_black_rook_btm", b, 1'b0, 14, 14);
      b = put_piece(start, 3, 1'b0, board_pkg::piece_empty);
      add_row("missing_white_queen", b, 1'b1, 0, 0);
      b = start;
      for (int s = 16; s < 32; s++)
         b = put_piece(b, s, 1'b0, board_pkg::piece_knight);
      for (int s = 32; s < 48; s++)
         b = put_piece(b, s, 1'b1, board_pkg::piece_pawn);
      add_row("full_board", b, 1'b1, 40, 33);   // Phase capped at 62
      kings = put_piece(put_piece('0, 4, 1'b0, board_pkg::piece_king), 60, 1'b1,
                        board_pkg::piece_king);
      add_row("kings_only", kings, 1'b1, 3, 5);
      add_row("king_knight_vs_king", put_piece(kings, 1, 1'b0, board_pkg::piece_knight),
              1'b1, 8, 5);
      add_row("king_vs_king_bishop", put_piece(kings, 61, 1'b1, board_pkg::piece_bishop),
              1'b0, 3, 9);
      add_row("king_pawn_vs_king", put_piece(kings, 12, 1'b0, board_pkg::piece_pawn),
              1'b1, 4, 5);
      b = put_piece(put_piece(kings, 0, 1'b0, board_pkg::piece_rook), 58, 1'b1,
                    board_pkg::piece_knight);
      add_row("rook_vs_knight", b, 1'b1, 14, 6);
      add_row("rook_vs_knight_btm", b, 1'b0, 14, 6);
      b = put_piece(put_piece(kings, 1, 1'b0, board_pkg::piece_knight), 6, 1'b0,
                    board_pkg::piece_knight);
      add_row("two_knights_vs_king", b, 1'b1, 10, 2);
      for (int n = 0; n < 8; n++)
      begin
         b = '0;
         for (int s = 0; s < 64; s++)
            if ($urandom_range(1, 0) == 1)   // Roughly half full
               b = put_piece(b, s, 1'($urandom_range(1, 0)),
                             board_pkg::piece_kind_e'(3'($urandom_range(6, 1))));
         add_row($sformatf("random_%0d", n), b, 1'($urandom_range(1, 0)),
                 $urandom_range(63, 0), $urandom_range(63, 0));
      end
   endtask

   task automatic run_row(int idx);
      stim_t   row;
      expect_t expected;
      string   name;
      int      edges;
      row = rows[idx];
      name = row_names[idx];
      expected = model_eval(row);
      @(posedge clk);
      board_in <= row.board;
      white_to_move <= row.white_to_move;
      attack_white_pop <= row.white_pop;
      attack_black_pop <= row.black_pop;
      board_valid <= 1'b1;
      @(posedge clk);   // Board frozen here
      board_valid <= 1'b0;
      board_in <= '0;
      repeat (idx % 4)
         @(posedge clk);
      is_attacking_done <= 1'b1;
      @(posedge clk);
      is_attacking_done <= 1'b0;
      edges = 0;
      @(negedge clk);
      while (!eval_valid && edges < 4 * `EVAL_LATENCY)
      begin
         @(negedge clk);
         edges++;
      end
      if (!eval_valid)
         stop_with_failure($sformatf("eval_valid never rose for %s", name));
      if (edges != `EVAL_LATENCY + 1)
         stop_with_failure($sformatf("eval_valid rose %0d edges after is_attacking_done for %s",
                                     edges, name));
      check_eval(name, expected.eval, eval);
      check_material(name, expected.material, material);
      check_flag({name, " insufficient"}, expected.insufficient, insufficient_material);
      @(posedge clk);
      board_in <= put_piece(row.board, 0, 1'b0, board_pkg::piece_queen);
      repeat (`EVAL_LATENCY)   // Long enough for a new board to reach eval
         @(posedge clk);
      @(negedge clk);
      check_eval({name, " held"}, expected.eval, eval);
      check_material({name, " held"}, expected.material, material);
      check_flag({name, " eval_valid held"}, 1'b1, eval_valid);
      @(posedge clk);
      clear_eval <= 1'b1;
      @(posedge clk);
      clear_eval <= 1'b0;
      @(negedge clk);
      check_flag({name, " eval_valid cleared"}, 1'b0, eval_valid);
   endtask

   initial
   begin
      void'($urandom(54790));
      clk = 1'b0;
      reset = 1'b1;
      board_valid = 1'b0;
      is_attacking_done = 1'b0;
      board_in = '0;
      clear_eval = 1'b0;
      white_to_move = 1'b1;
      attack_white_pop = '0;
      attack_black_pop = '0;
      build_table();
      repeat (10)
         @(posedge clk);
      reset <= 1'b0;
      repeat (4)
      begin
         @(negedge clk);
         check_flag("after_reset eval_valid", 1'b0, eval_valid);
      end
      for (int i = 0; i < rows.size(); i++)
         run_row(i);
      $display("RESULT: PASS");
      $finish;
   end

   // 40 cycles per row, one spare row for reset
   initial
   begin
      #1;
      #((rows.size() + 1) * 40 * 40);
      stop_with_failure("Timeout: the table did not finish in the time allowed");
   end

endmodule

//--- filelist.f
+incdir+verilog
+incdir+testbench
verilog/board_pkg.sv
verilog/eval_pkg.sv
verilog/rank_scorer.sv
verilog/score_accumulate.sv
verilog/phase_blend.sv
verilog/evaluate.sv
testbench/tb_evaluate.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module tb_evaluate

output=$(./obj_dir/Vtb_evaluate || true)
echo "$output"

if echo "$output" | grep -qx "RESULT: PASS"; then
   exit 0
fi
exit 1
